/* Bender.yml */
package:
  name: snake_display

sources:
  - include_dirs:
      - src
    files:
      - src/grid_pkg.sv
      - src/draw_pkg.sv
      - src/cell_query_if.sv
      - src/cell_change_if.sv
      - src/snake_body_store.sv
      - src/frame_tracker.sv
      - src/draw_cmd_fifo.sv
      - src/snake_display_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/snake_display_assertions.sv
      - verif/snake_display_tb.sv

/* project.f */
+incdir+src
src/grid_pkg.sv
src/draw_pkg.sv
src/cell_query_if.sv
src/cell_change_if.sv
src/snake_body_store.sv
src/frame_tracker.sv
src/draw_cmd_fifo.sv
src/snake_display_top.sv
verif/snake_display_assertions.sv
verif/snake_display_tb.sv

/* src/cell_change_if.sv */
`include "snake_defines.svh"

interface cell_change_if;

    logic                diff;  // One cycle strobe per change.
    grid_pkg::coord_t    x;
    grid_pkg::coord_t    y;
    grid_pkg::obj_code_t code;

    modport tracker (output diff, x, y, code);
    modport sink    (input diff, x, y, code);

endinterface

/* src/cell_query_if.sv */
`include "snake_defines.svh"

interface cell_query_if;

    grid_pkg::coord_t x;        // Scan cell.
    grid_pkg::coord_t y;
    logic             body;
    logic             head;
    logic             apple;
    logic             border;

    // Answer is combinational, same cycle.
    modport tracker (output x, y, input body, head, apple, border);
    modport store   (input x, y, output body, head, apple, border);

endinterface

/* src/draw_cmd_fifo.sv */
`include "snake_defines.svh"

module draw_cmd_fifo (
    input  logic                clk,
    input  logic                nrst,
    cell_change_if.sink         change,
    input  logic                pop,
    output logic                cmd_valid,
    output draw_pkg::draw_cmd_t cmd,
    output logic                overflow
);

    localparam int PTR_BITS = $clog2(`FIFO_DEPTH);
    localparam int CNT_BITS = $clog2(`FIFO_DEPTH + 1);
    localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(`FIFO_DEPTH - 1);

    draw_pkg::draw_cmd_t mem [`FIFO_DEPTH];
    draw_pkg::draw_cmd_t new_cmd;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                full;
    logic                do_push;
    logic                do_pop;

    always_comb begin
        new_cmd.op   = (change.code == grid_pkg::blank) ? draw_pkg::op_erase
                                                        : draw_pkg::op_paint;
        new_cmd.x    = change.x;
        new_cmd.y    = change.y;
        new_cmd.code = change.code;
    end

    assign full      = (count == CNT_BITS'(`FIFO_DEPTH));
    assign cmd_valid = (count != '0);
    assign do_pop    = pop && cmd_valid;
    assign do_push   = change.diff && !full;    // Full queue drops, even on a pop.
    assign cmd       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= new_cmd;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (change.diff && full) begin
                overflow <= 1'b1;               // Sticky.
            end
        end
    end

endmodule

/* src/draw_pkg.sv */
`include "snake_defines.svh"

package draw_pkg;

    // Erase when a cell goes blank, paint for everything else.
    typedef enum logic {
        op_erase = 1'b0,
        op_paint = 1'b1
    } draw_op_t;

    // One queued display update, 12 bits wide.
    typedef struct packed {
        draw_op_t            op;
        grid_pkg::coord_t    x;
        grid_pkg::coord_t    y;
        grid_pkg::obj_code_t code;
    } draw_cmd_t;

endpackage

/* src/frame_tracker.sv */
`include "snake_defines.svh"

module frame_tracker (
    input  logic           clk,
    input  logic           nrst,
    input  logic           enable,
    cell_query_if.tracker  query,
    cell_change_if.tracker change
);

    localparam grid_pkg::coord_t X_END = grid_pkg::coord_t'(`GRID_W - 1);
    localparam grid_pkg::coord_t Y_END = grid_pkg::coord_t'(`GRID_H - 1);

    grid_pkg::obj_code_t frame [`GRID_W][`GRID_H];
    grid_pkg::coord_t    cur_x;
    grid_pkg::coord_t    cur_y;
    grid_pkg::obj_code_t stored;
    grid_pkg::obj_code_t new_code;
    logic                on_edge;
    logic                changed;

    logic                diff_q;
    grid_pkg::coord_t    x_q;
    grid_pkg::coord_t    y_q;
    grid_pkg::obj_code_t code_q;

    assign query.x = cur_x;
    assign query.y = cur_y;

    assign stored  = frame[cur_x][cur_y];
    assign on_edge = (cur_x == 4'd0) || (cur_x == X_END) ||
                     (cur_y == 4'd0) || (cur_y == Y_END);

    // *******************************************************************
    // Raster scan, x fastest.
    // *******************************************************************
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cur_x <= '0;
            cur_y <= '0;
        end else if (enable) begin
            if (cur_x == X_END) begin
                cur_x <= '0;
                cur_y <= (cur_y == Y_END) ? 4'd0 : cur_y + 1'b1;
            end else begin
                cur_x <= cur_x + 1'b1;
            end
        end
    end

    // *******************************************************************
    // Object priority and change detection.
    // *******************************************************************
    always_comb begin
        if (on_edge) begin
            new_code = query.border ? grid_pkg::border_c : stored;
        end else if (query.body) begin
            new_code = grid_pkg::snake_body;
        end else if (query.head) begin
            new_code = grid_pkg::snake_head;
        end else if (query.apple) begin
            new_code = grid_pkg::apple_c;
        end else begin
            new_code = grid_pkg::blank;
        end
    end

    assign changed = (new_code != stored);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `GRID_W; i++) begin
                for (int j = 0; j < `GRID_H; j++) begin
                    frame[i][j] <= grid_pkg::blank;
                end
            end
        end else if (changed) begin
            frame[cur_x][cur_y] <= new_code;
        end
    end

    // Change record, aligned with its strobe.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            diff_q <= 1'b0;
        end else begin
            diff_q <= changed;
        end
    end

    always_ff @(posedge clk) begin
        x_q    <= cur_x;
        y_q    <= cur_y;
        code_q <= new_code;
    end

    assign change.diff = diff_q;
    assign change.x    = x_q;
    assign change.y    = y_q;
    assign change.code = code_q;

endmodule

/* src/grid_pkg.sv */
`include "snake_defines.svh"

package grid_pkg;

    // What a single playfield cell holds.
    typedef enum logic [2:0] {
        blank      = 3'd0,
        snake_head = 3'd1,
        snake_body = 3'd2,
        apple_c    = 3'd3,
        border_c   = 3'd4
    } obj_code_t;

    typedef logic [`COORD_BITS-1:0] coord_t;   // Cell column or row.

    // Snake heading, taken with each move strobe.
    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_down  = 2'd1,
        dir_left  = 2'd2,
        dir_up    = 2'd3
    } dir_t;

endpackage

/* src/snake_body_store.sv */
`include "snake_defines.svh"

module snake_body_store (
    input  logic             clk,
    input  logic             nrst,
    input  logic             move,
    input  logic             grow,
    input  grid_pkg::dir_t   dir,
    input  grid_pkg::coord_t apple_x,
    input  grid_pkg::coord_t apple_y,
    cell_query_if.store      query
);

    localparam int IDX_BITS = $clog2(`MAX_LEN);
    localparam int LEN_BITS = $clog2(`MAX_LEN + 1);

    localparam grid_pkg::coord_t X_EDGE  = grid_pkg::coord_t'(`GRID_W - 1);
    localparam grid_pkg::coord_t Y_EDGE  = grid_pkg::coord_t'(`GRID_H - 1);
    localparam grid_pkg::coord_t X_LAST  = grid_pkg::coord_t'(`GRID_W - 2);
    localparam grid_pkg::coord_t Y_LAST  = grid_pkg::coord_t'(`GRID_H - 2);
    localparam grid_pkg::coord_t START_X = grid_pkg::coord_t'(`GRID_W / 2);
    localparam grid_pkg::coord_t START_Y = grid_pkg::coord_t'(`GRID_H / 2);

    grid_pkg::coord_t    seg_x [`MAX_LEN];
    grid_pkg::coord_t    seg_y [`MAX_LEN];
    logic [IDX_BITS-1:0] head_idx;
    logic [IDX_BITS-1:0] next_idx;
    logic [LEN_BITS-1:0] len;
    grid_pkg::coord_t    head_x;
    grid_pkg::coord_t    head_y;
    grid_pkg::coord_t    next_x;
    grid_pkg::coord_t    next_y;
    logic                hit_body;

    assign head_x   = seg_x[head_idx];
    assign head_y   = seg_y[head_idx];
    assign next_idx = head_idx + 1'b1;     // Ring wraps on its own.

    // Next head cell, wrapping inside the border.
    always_comb begin
        next_x = head_x;
        next_y = head_y;
        case (dir)
            grid_pkg::dir_right: next_x = (head_x == X_LAST) ? 4'd1 : head_x + 1'b1;
            grid_pkg::dir_left:  next_x = (head_x == 4'd1) ? X_LAST : head_x - 1'b1;
            grid_pkg::dir_down:  next_y = (head_y == Y_LAST) ? 4'd1 : head_y + 1'b1;
            grid_pkg::dir_up:    next_y = (head_y == 4'd1) ? Y_LAST : head_y - 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `MAX_LEN; i++) begin
                seg_x[i] <= START_X;
                seg_y[i] <= START_Y;
            end
            seg_x[`MAX_LEN - 1] <= START_X - 4'd1;    // First body cell.
            seg_x[`MAX_LEN - 2] <= START_X - 4'd2;    // Tail.
            head_idx <= '0;
            len      <= LEN_BITS'(3);
        end else if (move) begin
            seg_x[next_idx] <= next_x;    // Overwrites the tail when full.
            seg_y[next_idx] <= next_y;
            head_idx        <= next_idx;
            if (grow && (len < LEN_BITS'(`MAX_LEN))) begin
                len <= len + 1'b1;
            end
        end
    end

    // Body covers live segments behind the head.
    always_comb begin
        logic [IDX_BITS-1:0] age;
        hit_body = 1'b0;
        for (int i = 0; i < `MAX_LEN; i++) begin
            age = head_idx - IDX_BITS'(i);
            if ((age != '0) && (LEN_BITS'(age) < len) &&
                (seg_x[i] == query.x) && (seg_y[i] == query.y)) begin
                hit_body = 1'b1;
            end
        end
    end

    assign query.body   = hit_body;
    assign query.head   = (query.x == head_x) && (query.y == head_y);
    assign query.apple  = (query.x == apple_x) && (query.y == apple_y);
    assign query.border = (query.x == 4'd0) || (query.x == X_EDGE) ||
                          (query.y == 4'd0) || (query.y == Y_EDGE);

endmodule

/* src/snake_defines.svh */
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// *******************************************************************
// Playfield geometry.
// *******************************************************************
`define GRID_W      16
`define GRID_H      12
`define COORD_BITS  4       // Covers both axes.

// *******************************************************************
// Storage sizes.
// *******************************************************************
`define MAX_LEN     16      // Snake ring capacity in segments.
`define FIFO_DEPTH  8       // Draw command queue entries.

`endif

/* src/snake_display_top.sv */
`include "snake_defines.svh"

module snake_display_top (
    input  logic                clk,
    input  logic                nrst,
    input  logic                move,
    input  logic                grow,
    input  grid_pkg::dir_t      dir,
    input  grid_pkg::coord_t    apple_x,
    input  grid_pkg::coord_t    apple_y,
    input  logic                enable,
    input  logic                pop,
    output logic                cmd_valid,
    output draw_pkg::draw_cmd_t cmd,
    output logic                overflow
);

    cell_query_if  query_bus ();
    cell_change_if change_bus ();

    // Snake state and per-cell classification.
    snake_body_store u_store (
        .clk     (clk),
        .nrst    (nrst),
        .move    (move),
        .grow    (grow),
        .dir     (dir),
        .apple_x (apple_x),
        .apple_y (apple_y),
        .query   (query_bus)
    );

    frame_tracker u_tracker (
        .clk    (clk),
        .nrst   (nrst),
        .enable (enable),
        .query  (query_bus),
        .change (change_bus)
    );

    // Change records queued for the display.
    draw_cmd_fifo u_fifo (
        .clk       (clk),
        .nrst      (nrst),
        .change    (change_bus),
        .pop       (pop),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .overflow  (overflow)
    );

endmodule

/* verif/snake_display_assertions.sv */
module snake_display_assertions (
    input logic                clk,
    input logic                nrst,
    input logic                pop,
    input logic                cmd_valid,
    input draw_pkg::draw_cmd_t cmd,
    input logic                overflow
);

    int unsigned fails = 0;

    // Oldest entry holds until it is popped.
    cmd_held: assert property (@(posedge clk) disable iff (!nrst)
        (cmd_valid && !pop) |=> $stable(cmd))
        else begin
            fails++;
            $error("cmd changed while valid and not popped");
        end

    empty_after_reset: assert property (@(posedge clk) $rose(nrst) |=> !cmd_valid)
        else begin
            fails++;
            $error("cmd_valid high right after reset release");
        end

    overflow_sticky: assert property (@(posedge clk) disable iff (!nrst)
        overflow |=> overflow)
        else begin
            fails++;
            $error("overflow cleared without reset");
        end

endmodule

bind snake_display_top snake_display_assertions u_assert (
    .clk       (clk),
    .nrst      (nrst),
    .pop       (pop),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .overflow  (overflow)
);

/* verif/snake_display_tb.sv */
`include "snake_defines.svh"

module snake_display_tb;

    localparam int TIMEOUT = 2000;      // Cycles allowed for any single wait.

    logic                clk;
    logic                nrst;
    logic                move;
    logic                grow;
    grid_pkg::dir_t      dir;
    grid_pkg::coord_t    apple_x;
    grid_pkg::coord_t    apple_y;
    logic                enable;
    logic                pop;
    logic                cmd_valid;
    draw_pkg::draw_cmd_t cmd;
    logic                overflow;

    // Reference model state.
    grid_pkg::coord_t    snake_x [$];   // Index 0 is the head.
    grid_pkg::coord_t    snake_y [$];
    grid_pkg::obj_code_t ref_frame [`GRID_W][`GRID_H];
    grid_pkg::coord_t    scan_x;
    grid_pkg::coord_t    scan_y;
    logic                pend_valid;    // Change record on its way to the queue.
    draw_pkg::draw_cmd_t pend_cmd;
    draw_pkg::draw_cmd_t exp_q [$];
    logic                exp_ovf;

    logic [31:0] rng;
    int          mismatches;
    int          failures;
    int          en_hold;
    int          seen [8];              // Paint commands popped, by object code.

    snake_display_top DUT (
        .clk       (clk),
        .nrst      (nrst),
        .move      (move),
        .grow      (grow),
        .dir       (dir),
        .apple_x   (apple_x),
        .apple_y   (apple_y),
        .enable    (enable),
        .pop       (pop),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // *******************************************************************
    // Compare tasks.
    // *******************************************************************
    task automatic check_cmd(input draw_pkg::draw_cmd_t exp, input draw_pkg::draw_cmd_t act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: cmd expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // *******************************************************************
    // Reference model.
    // *******************************************************************
    task automatic model_reset();
        snake_x = '{4'd8, 4'd7, 4'd6};
        snake_y = '{4'd6, 4'd6, 4'd6};
        foreach (ref_frame[i, j]) ref_frame[i][j] = grid_pkg::blank;
        scan_x     = '0;
        scan_y     = '0;
        pend_valid = 1'b0;
        exp_ovf    = 1'b0;
        exp_q.delete();
    endtask

    function automatic grid_pkg::obj_code_t expected_code(input grid_pkg::coord_t cx,
                                                          input grid_pkg::coord_t cy);
        logic at_edge;
        logic hit;
        at_edge = (cx == 0) || (cx == `GRID_W - 1) || (cy == 0) || (cy == `GRID_H - 1);
        hit     = 1'b0;
        for (int i = 1; i < snake_x.size(); i++) begin
            if ((snake_x[i] == cx) && (snake_y[i] == cy)) hit = 1'b1;
        end
        if (at_edge) return grid_pkg::border_c;    // Border flag is always set here.
        if (hit) return grid_pkg::snake_body;
        if ((cx == snake_x[0]) && (cy == snake_y[0])) return grid_pkg::snake_head;
        if ((cx == apple_x) && (cy == apple_y)) return grid_pkg::apple_c;
        return grid_pkg::blank;
    endfunction

    // One rising edge, using the inputs just driven.
    task automatic model_edge();
        int                  depth;
        grid_pkg::obj_code_t code;
        grid_pkg::coord_t    hx;
        grid_pkg::coord_t    hy;
        depth = exp_q.size();
        if (pop && (depth != 0)) void'(exp_q.pop_front());
        if (pend_valid) begin
            if (depth == `FIFO_DEPTH) exp_ovf = 1'b1;
            else exp_q.push_back(pend_cmd);
        end
        code       = expected_code(scan_x, scan_y);
        pend_valid = (code != ref_frame[scan_x][scan_y]);
        if (pend_valid) begin
            pend_cmd.op   = (code == grid_pkg::blank) ? draw_pkg::op_erase : draw_pkg::op_paint;
            pend_cmd.x    = scan_x;
            pend_cmd.y    = scan_y;
            pend_cmd.code = code;
            ref_frame[scan_x][scan_y] = code;
        end
        if (move) begin
            hx = snake_x[0];
            hy = snake_y[0];
            case (dir)
                grid_pkg::dir_right: hx = (hx == `GRID_W - 2) ? 4'd1 : hx + 4'd1;
                grid_pkg::dir_left:  hx = (hx == 4'd1) ? 4'(`GRID_W - 2) : hx - 4'd1;
                grid_pkg::dir_down:  hy = (hy == `GRID_H - 2) ? 4'd1 : hy + 4'd1;
                default:             hy = (hy == 4'd1) ? 4'(`GRID_H - 2) : hy - 4'd1;
            endcase
            snake_x.push_front(hx);
            snake_y.push_front(hy);
            if (!grow || (snake_x.size() > `MAX_LEN)) begin   // Tail leaves.
                void'(snake_x.pop_back());
                void'(snake_y.pop_back());
            end
        end
        if (enable) begin
            if (scan_x == `GRID_W - 1) begin
                scan_x = '0;
                scan_y = (scan_y == `GRID_H - 1) ? 4'd0 : scan_y + 4'd1;
            end else begin
                scan_x = scan_x + 4'd1;
            end
        end
    endtask

    task automatic check_outputs();
        check_flag("cmd_valid", exp_q.size() != 0, cmd_valid);
        check_flag("overflow", exp_ovf, overflow);
        if (exp_q.size() != 0) check_cmd(exp_q[0], cmd);
    endtask

    // *******************************************************************
    // Stimulus.
    // *******************************************************************
    // pop_mode and en_mode: 0 low, 1 high, 2 random.
    task automatic step(input int pop_mode, input int en_mode, input bit rnd_move,
                        input bit rnd_grow, input bit rnd_apple);
        logic [31:0] r;
        @(negedge clk);
        check_outputs();
        rng  = xorshift32(rng);
        r    = rng;
        move = rnd_move && (r[3:0] == 4'd0);
        grow = rnd_grow && r[4];
        dir  = grid_pkg::dir_t'(r[6:5]);
        pop  = (pop_mode == 2) ? (r[8:7] != 2'd0) : (pop_mode == 1);
        if (en_mode != 2) begin
            enable = (en_mode == 1);
        end else if (en_hold == 0) begin
            enable  = r[9];
            en_hold = int'(r[13:10]) + 1;       // Random stretch length.
        end else begin
            en_hold--;
        end
        if (rnd_apple && (r[17:14] == 4'd0)) begin
            apple_x = grid_pkg::coord_t'(1 + r[21:18] % 14);
            apple_y = grid_pkg::coord_t'(1 + r[25:22] % 10);
        end
        if (pop && cmd_valid && (cmd.op == draw_pkg::op_paint)) seen[cmd.code]++;
        model_edge();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        nrst    = 1'b0;
        move    = 1'b0;
        grow    = 1'b0;
        enable  = 1'b0;
        pop     = 1'b0;
        en_hold = 0;
        model_reset();
        repeat (5) begin
            @(negedge clk);
            check_outputs();
        end
        nrst = 1'b1;
        model_edge();
    endtask

    task automatic wait_overflow();
        int n;
        n = 0;
        while (!overflow && (n < TIMEOUT)) begin
            step(0, 1, 1'b0, 1'b0, 1'b0);
            n++;
        end
        if (!overflow) begin
            failures++;
            $display("Timeout: overflow never rose while nothing was popped");
        end
    endtask

    task automatic drain_queue();
        int n;
        n = 0;
        while ((cmd_valid || pend_valid || (exp_q.size() != 0)) && (n < TIMEOUT)) begin
            step(1, 0, 1'b0, 1'b0, 1'b0);
            n++;
        end
        if (cmd_valid) begin
            failures++;
            $display("Timeout: draw command queue did not drain");
        end
    endtask

    initial begin
        rng        = 32'h42c2e1ba;
        nrst       = 1'b0;
        move       = 1'b0;
        grow       = 1'b0;
        dir        = grid_pkg::dir_right;
        apple_x    = 4'd3;
        apple_y    = 4'd3;
        enable     = 1'b0;
        pop        = 1'b0;
        mismatches = 0;
        failures   = 0;
        en_hold    = 0;
        model_reset();

        apply_reset();
        wait_overflow();
        repeat (20) step(0, 1, 1'b0, 1'b0, 1'b0);

        // First frame with every command popped, apple kept off the snake row.
        rng     = xorshift32(rng);
        apple_x = grid_pkg::coord_t'(1 + rng[3:0] % 14);
        apple_y = grid_pkg::coord_t'(1 + rng[7:4] % 5);
        apply_reset();
        foreach (seen[i]) seen[i] = 0;
        repeat (`GRID_W * `GRID_H + 8) step(1, 1, 1'b0, 1'b0, 1'b0);
        check_count("border paints", 52, seen[grid_pkg::border_c]);
        check_count("head paints", 1, seen[grid_pkg::snake_head]);
        check_count("body paints", 2, seen[grid_pkg::snake_body]);
        check_count("apple paints", 1, seen[grid_pkg::apple_c]);

        repeat (1500) step(1, 1, 1'b1, 1'b0, 1'b0);    // Moves only.
        repeat (1500) step(1, 1, 1'b1, 1'b1, 1'b0);    // Moves with growth.
        repeat (1500) step(1, 2, 1'b0, 1'b0, 1'b1);    // Stalls and apple changes.
        repeat (4000) step(2, 2, 1'b1, 1'b1, 1'b1);
        drain_queue();

        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, DUT.u_assert.fails);
        if ((mismatches == 0) && (failures == 0) && (DUT.u_assert.fails == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
